//--- verilog/decode_pkg.sv
package decode_pkg;

  // **********************************************************************
  // Widths
  // **********************************************************************

  typedef logic [7:0]  byte_t;        // One instruction byte
  typedef logic [31:0] window_t;      // Four bytes, first byte lowest
  typedef logic [3:0]  rom_index_t;   // Microcode sequence index
  typedef logic [7:0]  uop_code_t;    // Micro-op code
  typedef logic [2:0]  step_t;        // Step within a sequence
  typedef logic [2:0]  byte_count_t;  // Bytes consumed by one instruction

  // **********************************************************************
  // Sequencer states
  // **********************************************************************

  typedef enum logic [1:0] {
    idle,          // Waiting for a decoded instruction
    issue_simple,  // Single micro-op on the output
    issue_rom      // ROM sequence playing out
  } seq_state_t;

  // **********************************************************************
  // Constants
  // **********************************************************************

  localparam byte_t opsize_prefix = 8'h66;

  // Simple micro-op code is this base ORed with opcode[6:0]
  localparam uop_code_t uop_simple_base = 8'h80;

  localparam int max_steps = 6;  // Longest sequence (IRET)

  // ROM sequence indexes
  localparam rom_index_t rom_iret       = 4'd2;
  localparam rom_index_t rom_call_far   = 4'd3;
  localparam rom_index_t rom_ret_near   = 4'd4;
  localparam rom_index_t rom_ret_far    = 4'd5;
  localparam rom_index_t rom_call_rel16 = 4'd8;
  localparam rom_index_t rom_call_rel32 = 4'd9;
  localparam rom_index_t rom_call_ind16 = 4'd10;
  localparam rom_index_t rom_call_ind32 = 4'd11;

endpackage

//--- verilog/uop_if.sv
`timescale 1ns/1ps

interface uop_if import decode_pkg::*; ();

  logic      valid;  // Micro-op present this cycle
  uop_code_t code;
  step_t     step;   // Position within the sequence
  logic      last;   // Final micro-op of the instruction

  // Sequencer side
  modport source (
    output valid,
    output code,
    output step,
    output last
  );

  // Consumer side
  modport sink (
    input valid,
    input code,
    input step,
    input last
  );

endinterface

//--- verilog/instr_byte_parser.sv
`timescale 1ns/1ps

module instr_byte_parser import decode_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        accept,
  input  window_t     instr_window,
  output logic        dec_valid,
  output logic        sizeop,
  output byte_t       opcode,
  output logic [2:0]  modrm_reg,
  output byte_count_t bytes_used
);

  byte_t       byte0;
  byte_t       byte1;
  byte_t       byte2;
  logic        prefix_hit;
  byte_t       opcode_next;
  byte_t       modrm_next;
  logic        has_modrm;
  byte_count_t count_next;

  // **********************************************************************
  // Field extraction from the raw window
  // **********************************************************************

  assign byte0 = instr_window[7:0];
  assign byte1 = instr_window[15:8];
  assign byte2 = instr_window[23:16];

  assign prefix_hit  = (byte0 == opsize_prefix);
  assign opcode_next = prefix_hit ? byte1 : byte0;  // Opcode follows the prefix
  assign modrm_next  = prefix_hit ? byte2 : byte1;

  // Only the FF group carries a ModRM byte in this subset
  assign has_modrm = (opcode_next == 8'hFF);

  assign count_next = byte_count_t'(1)
                    + byte_count_t'(prefix_hit)
                    + byte_count_t'(has_modrm);

  // **********************************************************************
  // Decode register
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;  // One cycle pulse per accepted window
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sizeop     <= prefix_hit;
      opcode     <= opcode_next;
      modrm_reg  <= modrm_next[5:3];  // Reg field of ModRM
      bytes_used <= count_next;
    end
  end

endmodule

//--- verilog/opcode_rom_control_cloud.sv
`timescale 1ns/1ps

module opcode_rom_control_cloud import decode_pkg::*; (
  input  logic       sizeop,
  input  byte_t      opcode,
  input  logic [2:0] modrm_reg,
  output rom_index_t rom_control,
  output logic       rom_in_control
);

  logic sizeop_n;
  logic and_e8;
  logic and_ff2;
  logic and_9a;
  logic and_c2;
  logic and_ca;
  logic and_cf;

  assign sizeop_n = ~sizeop;

  // **********************************************************************
  // Product terms
  // **********************************************************************

  // E8 either operand size
  assign and_e8 = opcode[7] & opcode[6] & opcode[5] & ~opcode[4]
                & opcode[3] & ~opcode[2] & ~opcode[1] & ~opcode[0];

  // FF /2 either operand size
  assign and_ff2 = (&opcode) & ~modrm_reg[2] & modrm_reg[1] & ~modrm_reg[0];

  assign and_9a = sizeop_n & opcode[7] & ~opcode[6] & ~opcode[5] & opcode[4]
                & opcode[3] & ~opcode[2] & opcode[1] & ~opcode[0];

  // C2 and C3, bit 0 free
  assign and_c2 = sizeop_n & opcode[7] & opcode[6] & ~opcode[5] & ~opcode[4]
                & ~opcode[3] & ~opcode[2] & opcode[1];

  // CA and CB, bit 0 free
  assign and_ca = sizeop_n & opcode[7] & opcode[6] & ~opcode[5] & ~opcode[4]
                & opcode[3] & ~opcode[2] & opcode[1];

  assign and_cf = sizeop_n & opcode[7] & opcode[6] & ~opcode[5] & ~opcode[4]
                & opcode[3] & opcode[2] & opcode[1] & opcode[0];

  // **********************************************************************
  // Sums per output bit
  // **********************************************************************

  assign rom_control[3] = and_e8 | and_ff2;                     // Near calls 8..11
  assign rom_control[2] = and_c2 | and_ca;                      // Returns 4, 5
  assign rom_control[1] = and_ff2 | and_9a | and_cf;
  assign rom_control[0] = (sizeop_n & and_e8) | (sizeop_n & and_ff2)
                        | and_9a | and_ca;                      // 32 bit forms odd

  assign rom_in_control = and_e8 | and_ff2 | and_9a | and_c2 | and_ca | and_cf;

endmodule

//--- verilog/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom import decode_pkg::*; (
  input  rom_index_t rom_sel,
  input  step_t      rom_step,
  output uop_code_t  rom_code,
  output logic       rom_last
);

  logic [2:0] seq_len;
  logic       known_index;

  // **********************************************************************
  // Sequence length table
  // **********************************************************************

  always_comb begin
    known_index = 1'b1;
    case (rom_sel)
      rom_call_rel16: seq_len = 3'd3;  // Push IP, load target, jump
      rom_call_rel32: seq_len = 3'd3;
      rom_call_ind16: seq_len = 3'd4;  // Extra load of the indirect target
      rom_call_ind32: seq_len = 3'd4;
      rom_ret_near:   seq_len = 3'd2;
      rom_ret_far:    seq_len = 3'd4;
      rom_call_far:   seq_len = 3'd5;
      rom_iret:       seq_len = 3'd6;  // Pops IP, CS and flags
      default: begin
        seq_len     = 3'd1;
        known_index = 1'b0;
      end
    endcase
  end

  // **********************************************************************
  // Code and end of sequence
  // **********************************************************************

  // Code is index * 16 + step
  assign rom_code = {rom_sel, 1'b0, rom_step};

  // Unknown index ends at once, and no sequence runs past max_steps
  assign rom_last = ~known_index
                  | (rom_step == step_t'(seq_len - 3'd1))
                  | (rom_step >= step_t'(max_steps - 1));

endmodule

//--- verilog/ucode_sequencer.sv
`timescale 1ns/1ps

module ucode_sequencer import decode_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       dec_valid,
  input  byte_t      opcode,
  input  rom_index_t rom_index,
  input  logic       rom_in_control,
  output rom_index_t rom_sel,
  output step_t      rom_step,
  input  uop_code_t  rom_code,
  input  logic       rom_last,
  output logic       instr_ready,
  uop_if.source      uop
);

  seq_state_t state;
  rom_index_t index_q;  // Index of the running sequence
  step_t      step_q;   // Next step to fetch from the ROM
  uop_code_t  simple_code;

  assign simple_code = uop_simple_base | {1'b0, opcode[6:0]};

  // Step 0 is looked up straight from the cloud while idle
  assign rom_sel  = (state == issue_rom) ? index_q : rom_index;
  assign rom_step = (state == issue_rom) ? step_q : '0;

  // Busy while the parser holds an instruction or a micro-op is pending
  assign instr_ready = (state == idle) & ~dec_valid;

  // **********************************************************************
  // State machine and output register
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      uop.valid <= 1'b0;
      uop.last  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (dec_valid) begin
            uop.valid <= 1'b1;
            uop.step  <= '0;
            if (rom_in_control) begin
              state    <= issue_rom;
              uop.code <= rom_code;
              uop.last <= rom_last;
              index_q  <= rom_index;
              step_q   <= step_t'(1);
            end else begin
              state    <= issue_simple;
              uop.code <= simple_code;
              uop.last <= 1'b1;
            end
          end
        end
        issue_simple: begin
          state     <= idle;
          uop.valid <= 1'b0;
          uop.last  <= 1'b0;
        end
        issue_rom: begin
          if (uop.last) begin  // Final step already on the output
            state     <= idle;
            uop.valid <= 1'b0;
            uop.last  <= 1'b0;
          end else begin
            uop.code <= rom_code;
            uop.last <= rom_last;
            uop.step <= step_q;
            step_q   <= step_q + 3'd1;
          end
        end
        default: begin
          state     <= idle;
          uop.valid <= 1'b0;
          uop.last  <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- verilog/decode_stage_top.sv
`timescale 1ns/1ps

module decode_stage_top import decode_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  window_t     instr_window,
  output logic        instr_ready,
  output logic        uop_valid,
  output uop_code_t   uop_code,
  output step_t       uop_step,
  output logic        uop_last,
  output byte_count_t bytes_used
);

  logic       accept;
  logic       dec_valid;
  logic       sizeop;
  byte_t      opcode;
  logic [2:0] modrm_reg;
  rom_index_t rom_index;
  logic       rom_in_control;
  rom_index_t rom_sel;
  step_t      rom_step;
  uop_code_t  rom_code;
  logic       rom_last;

  uop_if uop_i ();

  assign accept = instr_valid & instr_ready;

  instr_byte_parser parser_i (
    .clk         (clk),
    .reset       (reset),
    .accept      (accept),
    .instr_window(instr_window),
    .dec_valid   (dec_valid),
    .sizeop      (sizeop),
    .opcode      (opcode),
    .modrm_reg   (modrm_reg),
    .bytes_used  (bytes_used)
  );

  opcode_rom_control_cloud cloud_i (
    .sizeop        (sizeop),
    .opcode        (opcode),
    .modrm_reg     (modrm_reg),
    .rom_control   (rom_index),
    .rom_in_control(rom_in_control)
  );

  ucode_rom rom_i (
    .rom_sel (rom_sel),
    .rom_step(rom_step),
    .rom_code(rom_code),
    .rom_last(rom_last)
  );

  ucode_sequencer sequencer_i (
    .clk           (clk),
    .reset         (reset),
    .dec_valid     (dec_valid),
    .opcode        (opcode),
    .rom_index     (rom_index),
    .rom_in_control(rom_in_control),
    .rom_sel       (rom_sel),
    .rom_step      (rom_step),
    .rom_code      (rom_code),
    .rom_last      (rom_last),
    .instr_ready   (instr_ready),
    .uop           (uop_i.source)
  );

  // Micro-op bundle out to plain ports
  assign uop_valid = uop_i.valid;
  assign uop_code  = uop_i.code;
  assign uop_step  = uop_i.step;
  assign uop_last  = uop_i.last;

endmodule

//--- testbench/decode_stage_sva.sv
`timescale 1ns/1ps

module decode_stage_sva import decode_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      instr_valid,
  input logic      instr_ready,
  input logic      uop_valid,
  input uop_code_t uop_code,
  input step_t     uop_step,
  input logic      uop_last
);

  // **********************************************************************
  // Ready protocol
  // **********************************************************************

  idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> instr_ready && !uop_valid)
    else begin
      $error("stage busy right after reset");
      decode_stage_tb.sva_errors++;
    end

  busy_after_accept: assert property (@(posedge clk) disable iff (reset)
    instr_valid && instr_ready |=> !instr_ready)
    else begin
      $error("ready high after acceptance");
      decode_stage_tb.sva_errors++;
    end

  busy_until_last: assert property (@(posedge clk) disable iff (reset)
    !instr_ready && !(uop_valid && uop_last) |=> !instr_ready)
    else begin
      $error("ready rose before the last micro-op");
      decode_stage_tb.sva_errors++;
    end

  ready_after_last: assert property (@(posedge clk) disable iff (reset)
    uop_valid && uop_last |=> instr_ready)
    else begin
      $error("ready not back after the last micro-op");
      decode_stage_tb.sva_errors++;
    end

  // **********************************************************************
  // Sequence shape
  // **********************************************************************

  steps_consecutive: assert property (@(posedge clk) disable iff (reset)
    uop_valid && !uop_last |=> uop_valid && uop_step == $past(uop_step) + 3'd1)
    else begin
      $error("sequence step skipped");
      decode_stage_tb.sva_errors++;
    end

  length_bounded: assert property (@(posedge clk) disable iff (reset)
    uop_valid |-> uop_step < step_t'(max_steps))
    else begin
      $error("sequence longer than max_steps");
      decode_stage_tb.sva_errors++;
    end

  rom_first_code: assert property (@(posedge clk) disable iff (reset)
    uop_valid && uop_step == 3'd0 && !uop_last |-> uop_code[3:0] == 4'd0)
    else begin
      $error("first ROM code not on index boundary");
      decode_stage_tb.sva_errors++;
    end

  // A single micro-op is always a simple one
  simple_first_code: assert property (@(posedge clk) disable iff (reset)
    uop_valid && uop_step == 3'd0 && uop_last |-> uop_code[7])
    else begin
      $error("simple code without base bit");
      decode_stage_tb.sva_errors++;
    end

endmodule

//--- testbench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

  logic        clk;
  logic        reset;
  logic        instr_valid;
  window_t     instr_window;
  logic        instr_ready;
  logic        uop_valid;
  uop_code_t   uop_code;
  step_t       uop_step;
  logic        uop_last;
  byte_count_t bytes_used;

  int value_errors = 0;
  int sva_errors   = 0;  // Raised by the bound assertions
  int cycle        = 0;
  int last_cycle   = 0;
  logic seen_accept = 1'b0;

  window_t     win_q[$];
  uop_code_t   exp_code[$];
  step_t       exp_step[$];
  logic        exp_last[$];
  byte_count_t exp_bytes[$];
  int          acc_cycle[$];

  decode_stage_top decode_stage_top_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr_window(instr_window),
    .instr_ready (instr_ready),
    .uop_valid   (uop_valid),
    .uop_code    (uop_code),
    .uop_step    (uop_step),
    .uop_last    (uop_last),
    .bytes_used  (bytes_used)
  );

  always #4 clk = ~clk;

  // **********************************************************************
  // Reference model
  // **********************************************************************

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Sequence index from the decode rule, -1 for a simple instruction
  function automatic int rule_index(input logic pfx, input byte_t op, input logic [2:0] reg_f);
    if (op == 8'hE8) return pfx ? 8 : 9;
    if (op == 8'hFF && reg_f == 3'd2) return pfx ? 10 : 11;
    if (pfx) return -1;
    case (op)
      8'h9A:        return 3;
      8'hC2, 8'hC3: return 4;
      8'hCA, 8'hCB: return 5;
      8'hCF:        return 2;
      default:      return -1;
    endcase
  endfunction

  function automatic int seq_length(input int idx);
    case (idx)
      8, 9:    return 3;
      10, 11:  return 4;
      4:       return 2;
      5:       return 4;
      3:       return 5;
      2:       return 6;
      default: return 1;
    endcase
  endfunction

  function automatic logic is_rom_opcode(input byte_t op);
    return op inside {8'hE8, 8'hFF, 8'h9A, 8'hC2, 8'hC3, 8'hCA, 8'hCB, 8'hCF};
  endfunction

  // Queues the window and every micro-op it should produce
  task automatic add_instr(input window_t w);
    logic  pfx;
    byte_t op;
    byte_t modrm;
    int    idx;
    int    len;
    pfx   = (w[7:0] == 8'h66);
    op    = pfx ? w[15:8] : w[7:0];
    modrm = pfx ? w[23:16] : w[15:8];
    idx   = rule_index(pfx, op, modrm[5:3]);
    len   = seq_length(idx);
    win_q.push_back(w);
    for (int s = 0; s < len; s++) begin
      if (idx < 0) exp_code.push_back(8'h80 | {1'b0, op[6:0]});
      else exp_code.push_back(uop_code_t'(idx * 16 + s));
      exp_step.push_back(step_t'(s));
      exp_last.push_back(s == len - 1);
      exp_bytes.push_back(byte_count_t'(1 + pfx + (op == 8'hFF)));
    end
  endtask

  task automatic send_window(input window_t w);
    @(negedge clk);
    while (!instr_ready) @(negedge clk);
    instr_valid  = 1'b1;
    instr_window = w;
    @(negedge clk);
    instr_valid  = 1'b0;
  endtask

  // **********************************************************************
  // Output monitor
  // **********************************************************************

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!reset) begin
      if (!seen_accept && (!instr_ready || uop_valid)) begin
        $display("Error at %0t: stage not idle before the first window", $time);
        value_errors++;
      end
      if (instr_valid && instr_ready) begin
        seen_accept = 1'b1;
        acc_cycle.push_back(cycle);
      end
      if (uop_valid) begin
        if (exp_code.size() == 0) begin
          $display("Error at %0t: micro-op seen with none expected", $time);
          value_errors++;
        end else begin
          if (uop_code !== exp_code[0]) begin
            $display("Error at %0t: uop_code expected %h got %h", $time, exp_code[0], uop_code);
            value_errors++;
          end
          if (uop_step !== exp_step[0]) begin
            $display("Error at %0t: uop_step expected %0d got %0d", $time, exp_step[0], uop_step);
            value_errors++;
          end
          if (uop_last !== exp_last[0]) begin
            $display("Error at %0t: uop_last expected %b got %b", $time, exp_last[0], uop_last);
            value_errors++;
          end
          if (bytes_used !== exp_bytes[0]) begin
            $display("Error at %0t: bytes_used expected %0d got %0d",
                     $time, exp_bytes[0], bytes_used);
            value_errors++;
          end
          if (exp_step[0] == 0) begin
            if (acc_cycle.size() == 0 || cycle != acc_cycle[0] + 2) begin
              $display("Error at %0t: first micro-op not 2 cycles after acceptance", $time);
              value_errors++;
            end
            if (acc_cycle.size() != 0) void'(acc_cycle.pop_front());
          end else if (cycle != last_cycle + 1) begin
            $display("Error at %0t: sequence micro-ops not on consecutive cycles", $time);
            value_errors++;
          end
          last_cycle = cycle;
          void'(exp_code.pop_front());
          void'(exp_step.pop_front());
          void'(exp_last.pop_front());
          void'(exp_bytes.pop_front());
        end
      end
    end
  end

  // **********************************************************************
  // Stimulus
  // **********************************************************************

  initial begin
    logic [31:0] seed;
    byte_t       op;
    int          picked;
    int          limit;
    clk          = 1'b0;
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr_window = '0;
    seed         = 32'h9831;

    add_instr(32'h0012_34E8);  // CALL rel32
    add_instr(32'h0034_E866);  // CALL rel16
    add_instr(32'h0000_D0FF);  // CALL FF /2
    add_instr(32'h00D0_FF66);
    add_instr(32'h0000_D8FF);  // FF /3 is simple
    add_instr(32'h00D8_FF66);
    add_instr(32'h0000_009A);
    add_instr(32'h0000_9A66);
    add_instr(32'h0000_00C2);
    add_instr(32'h0000_C266);
    add_instr(32'h0000_00C3);
    add_instr(32'h0000_C366);
    add_instr(32'h0000_00CA);
    add_instr(32'h0000_CA66);
    add_instr(32'h0000_00CB);
    add_instr(32'h0000_CB66);
    add_instr(32'h0000_00CF);
    add_instr(32'h0000_CF66);
    picked = 0;
    while (picked < 40) begin
      seed = lcg_next(seed);
      op   = seed[23:16];
      if (!is_rom_opcode(op) && op != opsize_prefix) begin
        add_instr({seed[15:0], seed[31:24], op});
        picked++;
      end
    end

    limit = exp_code.size() + 4 * win_q.size() + 100;
    fork
      begin
        repeat (limit) @(posedge clk);
        $display("Timeout: the stage did not finish all instructions in time");
        $display("Errors found");
        $finish;
      end
    join_none

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);

    foreach (win_q[i]) send_window(win_q[i]);
    while (exp_code.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);

    $display("value errors %0d, assertion errors %0d", value_errors, sva_errors);
    if (value_errors == 0 && sva_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  bind decode_stage_top decode_stage_sva decode_stage_sva_i (
    .clk        (clk),
    .reset      (reset),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .uop_valid  (uop_valid),
    .uop_code   (uop_code),
    .uop_step   (uop_step),
    .uop_last   (uop_last)
  );

endmodule

//--- src.f
verilog/decode_pkg.sv
verilog/uop_if.sv
verilog/instr_byte_parser.sv
verilog/opcode_rom_control_cloud.sv
verilog/ucode_rom.sv
verilog/ucode_sequencer.sv
verilog/decode_stage_top.sv
testbench/decode_stage_sva.sv
testbench/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - verilog/decode_pkg.sv
  - verilog/uop_if.sv
  - verilog/instr_byte_parser.sv
  - verilog/opcode_rom_control_cloud.sv
  - verilog/ucode_rom.sv
  - verilog/ucode_sequencer.sv
  - verilog/decode_stage_top.sv
  - target: test
    files:
      - testbench/decode_stage_sva.sv
      - testbench/decode_stage_tb.sv
